//--- Makefile
VERILATOR ?= verilator
TOP       ?= hart_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+hw
+incdir+test
hw/hart_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/hart.sv
test/hart_tb.sv

//--- hw/decode_stage.sv
`timescale 1ns/10ps
`include "hart_settings.svh"

module decode_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  hart_pkg::word_t      i_inst,
    input  hart_pkg::word_t      i_pc,
    input  logic                 i_valid,
    input  hart_pkg::reg_write_t i_ex_bypass,
    input  hart_pkg::reg_write_t i_wb_write,
    output logic                 o_halt,
    output hart_pkg::dec_to_ex_t o_ex
);
    import hart_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;
    logic       is_ebreak;
    logic       rd_wen;
    alu_op_e    alu_op;
    word_t      imm;
    reg_addr_t  rs1_raddr;
    reg_addr_t  rs2_raddr;
    word_t      rf_rs1_rdata;
    word_t      rf_rs2_rdata;
    word_t      rs1_rdata;
    word_t      rs2_rdata;
    logic       word_valid;
    logic       halted_q;
    dec_to_ex_t ex_d;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    // only funct7 values defined by RV32I are accepted
    // sub and sra share funct7 0x20, every other operation needs zero
    assign is_op = (opcode == `HART_OPC_OP) &&
                   ((funct7 == 7'h00) ||
                    ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101))));

    // immediate shifts reuse the funct7 field, other immediates take any value
    always_comb begin
        is_op_imm = 1'b0;
        if (opcode == `HART_OPC_OP_IMM) begin
            case (funct3)
                3'b001:  is_op_imm = (funct7 == 7'h00);
                3'b101:  is_op_imm = (funct7 == 7'h00) || (funct7 == 7'h20);
                default: is_op_imm = 1'b1;
            endcase
        end
    end

    assign is_lui    = (opcode == `HART_OPC_LUI);
    assign is_ebreak = (i_inst == `HART_EBREAK);
    assign rd_wen    = is_op | is_op_imm | is_lui;

    // funct3 picks the operation, bit 30 separates add/sub and srl/sra
    // addi has no subtract form so bit 30 only counts for register ops
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        // lui is an add of the upper immediate to x0
        if (is_lui) begin
            alu_op = ALU_ADD;
        end
    end

    // U-type for lui, sign-extended I-type for everything else
    assign imm = is_lui ? {i_inst[31:12], 12'b0} : {{20{i_inst[31]}}, i_inst[31:20]};

    // unused sources read as x0 so that their data is zero as well
    assign rs1_raddr = (is_op | is_op_imm) ? i_inst[19:15] : '0;
    assign rs2_raddr = is_op ? i_inst[24:20] : '0;

    reg_file u_reg_file (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_write     (i_wb_write),
        .i_rs1_raddr (rs1_raddr),
        .i_rs2_raddr (rs2_raddr),
        .o_rs1_rdata (rf_rs1_rdata),
        .o_rs2_rdata (rf_rs2_rdata)
    );

    // the instruction one ahead is still in execute and has not written yet
    function automatic word_t bypass(reg_addr_t addr, word_t rf_data, reg_write_t fwd);
        if (fwd.en && (addr != '0) && (fwd.addr == addr)) begin
            return fwd.data;
        end
        return rf_data;
    endfunction

    assign rs1_rdata = bypass(rs1_raddr, rf_rs1_rdata, i_ex_bypass);
    assign rs2_rdata = bypass(rs2_raddr, rf_rs2_rdata, i_ex_bypass);

    // words arriving after an accepted ebreak are dropped here
    assign word_valid = i_valid & ~halted_q;

    always_comb begin
        ex_d.valid     = word_valid;
        ex_d.trap      = ~(rd_wen | is_ebreak);
        ex_d.halt      = is_ebreak;
        ex_d.alu_op    = alu_op;
        ex_d.inst      = i_inst;
        ex_d.pc        = i_pc;
        ex_d.rs1_raddr = rs1_raddr;
        ex_d.rs2_raddr = rs2_raddr;
        ex_d.rs1_rdata = rs1_rdata;
        ex_d.rs2_rdata = rs2_rdata;
        ex_d.op_b      = is_op ? rs2_rdata : imm;
        ex_d.rd_waddr  = rd_wen ? i_inst[11:7] : '0;
        ex_d.rd_wen    = rd_wen;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halted_q <= 1'b0;
            o_ex     <= '0;
        end else begin
            // sticky until reset, fetch stops on this level
            if (word_valid && is_ebreak) begin
                halted_q <= 1'b1;
            end
            o_ex <= ex_d;
        end
    end

    assign o_halt = halted_q;

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  hart_pkg::dec_to_ex_t i_ex,
    output hart_pkg::reg_write_t o_bypass,
    output hart_pkg::retire_t    o_wb
);
    import hart_pkg::*;

    word_t    op_a;
    word_t    op_b;
    logic [4:0] shamt;
    word_t    result;
    retire_t  wb_d;

    assign op_a  = i_ex.rs1_rdata;
    assign op_b  = i_ex.op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_ex.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = word_t'(op_a < op_b);
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = '0;
        endcase
    end

    // result goes straight back to decode for the instruction right behind
    // decode ignores a bypass to x0
    assign o_bypass.en   = i_ex.valid & i_ex.rd_wen;
    assign o_bypass.addr = i_ex.rd_waddr;
    assign o_bypass.data = result;

    always_comb begin
        wb_d.valid     = i_ex.valid;
        wb_d.trap      = i_ex.trap;
        wb_d.halt      = i_ex.halt;
        wb_d.inst      = i_ex.inst;
        wb_d.pc        = i_ex.pc;
        // no control flow, every instruction falls through
        wb_d.next_pc   = i_ex.pc + word_t'(4);
        wb_d.rs1_raddr = i_ex.rs1_raddr;
        wb_d.rs2_raddr = i_ex.rs2_raddr;
        wb_d.rs1_rdata = i_ex.rs1_rdata;
        wb_d.rs2_rdata = i_ex.rs2_rdata;
        wb_d.rd_waddr  = i_ex.rd_waddr;
        // trap and ebreak report zero write data
        wb_d.rd_wdata  = i_ex.rd_wen ? result : '0;
    end

    // this is the register that holds the instruction in writeback
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb <= '0;
        end else begin
            o_wb <= wb_d;
        end
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/10ps
`include "hart_settings.svh"

module fetch_stage (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_halt,
    output hart_pkg::word_t o_imem_raddr,
    output hart_pkg::word_t o_pc,
    output logic            o_valid
);
    import hart_pkg::*;

    // address currently presented to the instruction memory
    word_t pc_q;
    // address of the word that memory returns this cycle
    word_t pc_d1_q;
    logic  valid_q;

    // there are no branches, so the pc only ever walks forward
    // once decode has seen ebreak the pc freezes until reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q    <= `HART_RESET_ADDR;
            valid_q <= 1'b0;
        end else begin
            if (!i_halt) begin
                pc_q <= pc_q + word_t'(4);
            end
            // memory answers one cycle after the address so the valid bit
            // follows the address by the same cycle
            valid_q <= !i_halt;
        end
    end

    // delayed pc lines up with the returning instruction word
    always_ff @(posedge i_clk) begin
        pc_d1_q <= pc_q;
    end

    assign o_imem_raddr = pc_q;
    assign o_pc         = pc_d1_q;
    assign o_valid      = valid_q;

endmodule

//--- hw/hart.sv
`timescale 1ns/10ps

module hart (
    input  logic              i_clk,
    input  logic              i_rst_n,
    output hart_pkg::word_t   o_imem_raddr,
    input  hart_pkg::word_t   i_imem_rdata,
    output hart_pkg::retire_t o_retire
);
    import hart_pkg::*;

    // fetch to decode
    word_t      fe_pc;
    logic       fe_valid;

    // decode back to fetch and forward to execute
    logic       de_halt;
    dec_to_ex_t de_ex;

    // execute to writeback, and its bypass back to decode
    reg_write_t ex_bypass;
    retire_t    ex_wb;

    // writeback into the register file inside decode
    reg_write_t wb_write;

    fetch_stage u_fetch (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_halt       (de_halt),
        .o_imem_raddr (o_imem_raddr),
        .o_pc         (fe_pc),
        .o_valid      (fe_valid)
    );

    // the instruction word comes directly from the synchronous memory
    decode_stage u_decode (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_inst      (i_imem_rdata),
        .i_pc        (fe_pc),
        .i_valid     (fe_valid),
        .i_ex_bypass (ex_bypass),
        .i_wb_write  (wb_write),
        .o_halt      (de_halt),
        .o_ex        (de_ex)
    );

    execute_stage u_execute (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ex     (de_ex),
        .o_bypass (ex_bypass),
        .o_wb     (ex_wb)
    );

    writeback_stage u_writeback (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb        (ex_wb),
        .o_retire    (o_retire),
        .o_reg_write (wb_write)
    );

endmodule

//--- hw/hart_pkg.sv
`include "hart_settings.svh"

package hart_pkg;

    // one machine word and one register index
    typedef logic [`HART_XLEN-1:0] word_t;
    typedef logic [`HART_REG_AW-1:0] reg_addr_t;

    // operations of the integer ALU
    // shifts take their amount from the low five bits of operand b
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // a single register write, used both for the execute bypass and the
    // write port of the register file
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    // everything execute needs, plus the fields that only travel on to retire
    typedef struct packed {
        logic      valid;
        logic      trap;
        logic      halt;
        alu_op_e   alu_op;
        word_t     inst;
        word_t     pc;
        reg_addr_t rs1_raddr;
        reg_addr_t rs2_raddr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        // second ALU operand, either rs2 data or the immediate
        word_t     op_b;
        reg_addr_t rd_waddr;
        logic      rd_wen;
    } dec_to_ex_t;

    // record of one retired instruction, as seen on the retire port
    typedef struct packed {
        logic      valid;
        logic      trap;
        logic      halt;
        word_t     inst;
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rs1_raddr;
        reg_addr_t rs2_raddr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        reg_addr_t rd_waddr;
        word_t     rd_wdata;
    } retire_t;

endpackage

//--- hw/hart_settings.svh
`ifndef HART_SETTINGS_SVH
`define HART_SETTINGS_SVH

// width of a data word and of every address in the hart
`define HART_XLEN 32

// five bits select one of the general registers
`define HART_REG_AW 5

// x0 is counted here even though it is never stored
`define HART_NUM_REGS 32

// the first instruction is fetched from this address once reset is released
`define HART_RESET_ADDR 32'h0000_0000

// major opcodes handled by this core
// everything else that is not ebreak retires as an illegal instruction
`define HART_OPC_OP     7'b0110011
`define HART_OPC_OP_IMM 7'b0010011
`define HART_OPC_LUI    7'b0110111

// ebreak is matched on the full word because the SYSTEM opcode is not decoded
`define HART_EBREAK 32'h0010_0073

`endif

//--- hw/reg_file.sv
`timescale 1ns/10ps
`include "hart_settings.svh"

module reg_file (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  hart_pkg::reg_write_t i_write,
    input  hart_pkg::reg_addr_t  i_rs1_raddr,
    input  hart_pkg::reg_addr_t  i_rs2_raddr,
    output hart_pkg::word_t      o_rs1_rdata,
    output hart_pkg::word_t      o_rs2_rdata
);
    import hart_pkg::*;

    // x0 has no storage
    word_t regs_q [1:`HART_NUM_REGS-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < `HART_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_write.en && (i_write.addr != '0)) begin
            regs_q[i_write.addr] <= i_write.data;
        end
    end

    // the write that lands at the next edge is already visible to the reader
    // this covers the instruction sitting in writeback
    function automatic word_t read_port(reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (i_write.en && (i_write.addr == addr)) begin
            data = i_write.data;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_rs1_rdata = read_port(i_rs1_raddr);
        o_rs2_rdata = read_port(i_rs2_raddr);
    end

endmodule

//--- hw/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  hart_pkg::retire_t    i_wb,
    output hart_pkg::retire_t    o_retire,
    output hart_pkg::reg_write_t o_reg_write
);

    logic halt_seen_q;
    logic retire_ok;

    // once ebreak has retired the port stays quiet until reset
    // decode already drops later words, this keeps the port closed as well
    assign retire_ok = i_wb.valid & ~halt_seen_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halt_seen_q <= 1'b0;
        end else if (retire_ok && i_wb.halt) begin
            halt_seen_q <= 1'b1;
        end
    end

    always_comb begin
        o_retire       = i_wb;
        o_retire.valid = retire_ok;
    end

    // trapping instructions never touch the register file
    // writes to x0 are dropped here so the register file only sees real ones
    assign o_reg_write.en   = retire_ok & ~i_wb.trap & (i_wb.rd_waddr != '0);
    assign o_reg_write.addr = i_wb.rd_waddr;
    assign o_reg_write.data = i_wb.rd_wdata;

endmodule

//--- test/hart_model.svh
`ifndef HART_MODEL_SVH
`define HART_MODEL_SVH

// generator state and the in-order architectural state of the model
logic [15:0] lfsr_state;
word_t       model_regs [`HART_NUM_REGS];
word_t       model_pc;

// one Fibonacci step, the feedback bit is also the bit handed out
function automatic logic lfsr_step();
    logic fb;
    fb = ^(lfsr_state & LFSR_TAPS);
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

// collects n bits, one LFSR step per bit
function automatic word_t rand_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

// major opcodes of groups this core does not implement, so all of them trap
function automatic logic [6:0] dropped_opcode(logic [1:0] sel);
    case (sel)
        2'd0:    return 7'b0000011;
        2'd1:    return 7'b0100011;
        2'd2:    return 7'b1100011;
        default: return 7'b0010111;
    endcase
endfunction

// registers stay within x0..x7 so that most instructions depend on a recent one
task automatic build_program();
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    lfsr_state = LFSR_SEED;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
        rd  = 3'(rand_bits(3));
        rs1 = 3'(rand_bits(3));
        rs2 = 3'(rand_bits(3));
        f3  = 3'(rand_bits(3));
        // the alternate encoding only exists for sub and the right shifts
        f7  = ((rand_bits(1) == 1) && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
        if (rand_bits(4) == 0) begin
            prog[PROG_AW'(i)] = {25'(rand_bits(25)), dropped_opcode(2'(rand_bits(2)))};
        end else begin
            case (2'(rand_bits(2)))
                2'd0, 2'd1: begin
                    prog[PROG_AW'(i)] = {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd,
                                         `HART_OPC_OP};
                end
                2'd2: begin
                    imm = 12'(rand_bits(12));
                    // shift immediates carry funct7 in their upper seven bits
                    if ((f3 == 3'd1) || (f3 == 3'd5)) begin
                        imm[11:5] = f7;
                    end
                    prog[PROG_AW'(i)] = {imm, 2'b00, rs1, f3, 2'b00, rd, `HART_OPC_OP_IMM};
                end
                default: begin
                    prog[PROG_AW'(i)] = {20'(rand_bits(20)), 2'b00, rd, `HART_OPC_LUI};
                end
            endcase
        end
    end
    prog[PROG_AW'(PROG_LEN - 1)] = `HART_EBREAK;
endtask

// RV32I integer operations, alt selects sub and the arithmetic right shift
function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic reset_model();
    model_regs = '{default: '0};
    model_pc   = `HART_RESET_ADDR;
endtask

// executes one instruction on the model and returns its retire record
function automatic retire_t step_model(word_t inst);
    retire_t    r;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_op;
    logic       is_imm;
    logic       is_lui;
    word_t      res;
    opc    = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    is_op  = (opc == `HART_OPC_OP) &&
             ((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
    is_imm = (opc == `HART_OPC_OP_IMM) && !((f3 == 3'd1) && (f7 != 7'h00)) &&
             !((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
    is_lui = (opc == `HART_OPC_LUI);
    r         = '0;
    r.valid   = 1'b1;
    r.inst    = inst;
    r.pc      = model_pc;
    r.next_pc = model_pc + 32'd4;
    // a source the instruction does not use is reported as x0
    if (is_op || is_imm) begin
        r.rs1_raddr = inst[19:15];
    end
    if (is_op) begin
        r.rs2_raddr = inst[24:20];
    end
    r.rs1_rdata = model_regs[r.rs1_raddr];
    r.rs2_rdata = model_regs[r.rs2_raddr];
    if (is_op) begin
        res = alu_ref(f3, f7[5], r.rs1_rdata, r.rs2_rdata);
    end else if (is_imm) begin
        res = alu_ref(f3, (f3 == 3'd5) && f7[5], r.rs1_rdata,
                      {{20{inst[31]}}, inst[31:20]});
    end else begin
        res = {inst[31:12], 12'b0};
    end
    if (is_op || is_imm || is_lui) begin
        r.rd_waddr = inst[11:7];
        r.rd_wdata = res;
        if (r.rd_waddr != '0) begin
            model_regs[r.rd_waddr] = res;
        end
    end else if (inst == `HART_EBREAK) begin
        r.halt = 1'b1;
    end else begin
        r.trap = 1'b1;
    end
    model_pc = model_pc + 32'd4;
    return r;
endfunction

`endif

//--- test/hart_tb.sv
`timescale 1ns/10ps
`include "hart_settings.svh"

module hart_tb;
    import hart_pkg::*;

    localparam int PROG_LEN     = 64;
    localparam int PROG_AW      = $clog2(PROG_LEN);
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    // the record for address A is registered three edges after A, so the
    // first rising edge that samples it is the fourth one after reset
    localparam int FIRST_RETIRE_EDGE = 4;
    localparam int DRAIN_CYCLES      = 8;
    localparam int TIMEOUT_NS        = (PROG_LEN + 20) * CLK_PERIOD * 2;
    localparam logic [15:0] LFSR_SEED = 16'd92;
    // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic    clk;
    logic    rst_n;
    word_t   imem_raddr;
    word_t   imem_rdata = '0;
    word_t   imem_addr_q;
    retire_t retire;
    word_t   prog [PROG_LEN];
    int      retired       = 0;
    int      value_errors  = 0;
    int      timing_errors = 0;

    `include "hart_model.svh"

    hart u_hart (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .o_imem_raddr (imem_raddr),
        .i_imem_rdata (imem_rdata),
        .o_retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // beyond the program the memory returns a pattern built from the whole address
    function automatic word_t imem_word(word_t addr);
        int idx;
        idx = int'((addr - `HART_RESET_ADDR) >> 2);
        if ((idx >= 0) && (idx < PROG_LEN)) begin
            return prog[PROG_AW'(idx)];
        end
        return ~addr;
    endfunction

    // the memory takes the address at the rising edge and returns the word
    // at the falling edge after it
    always @(posedge clk) begin
        imem_addr_q <= imem_raddr;
    end

    always @(negedge clk) begin
        imem_rdata <= imem_word(imem_addr_q);
    end

    // fetch steps one word per edge and ends up two words past ebreak
    // halt only reaches fetch once decode has registered the ebreak
    function automatic word_t expected_fetch_addr(int edge_idx);
        int steps;
        steps = edge_idx - 1;
        if (steps > PROG_LEN + 1) begin
            steps = PROG_LEN + 1;
        end
        return `HART_RESET_ADDR + word_t'(4 * steps);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            value_errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    task automatic check_retire(input int idx, input retire_t got, input retire_t expected);
        string tag;
        tag = $sformatf("retire[%0d]", idx);
        check_word({tag, ".trap"}, word_t'(got.trap), word_t'(expected.trap));
        check_word({tag, ".halt"}, word_t'(got.halt), word_t'(expected.halt));
        check_word({tag, ".inst"}, got.inst, expected.inst);
        check_word({tag, ".pc"}, got.pc, expected.pc);
        check_word({tag, ".next_pc"}, got.next_pc, expected.next_pc);
        check_word({tag, ".rs1_raddr"}, word_t'(got.rs1_raddr), word_t'(expected.rs1_raddr));
        check_word({tag, ".rs2_raddr"}, word_t'(got.rs2_raddr), word_t'(expected.rs2_raddr));
        check_word({tag, ".rs1_rdata"}, got.rs1_rdata, expected.rs1_rdata);
        check_word({tag, ".rs2_rdata"}, got.rs2_rdata, expected.rs2_rdata);
        check_word({tag, ".rd_waddr"}, word_t'(got.rd_waddr), word_t'(expected.rd_waddr));
        check_word({tag, ".rd_wdata"}, got.rd_wdata, expected.rd_wdata);
    endtask

    task automatic report_counts();
        $display("retired %0d of %0d, value errors %0d, timing errors %0d",
                 retired, PROG_LEN, value_errors, timing_errors);
    endtask

    // instructions retire one per cycle in program order from a fixed edge on
    initial begin : retire_checker
        retire_t expected;
        int      edge_cnt;
        edge_cnt = 0;
        reset_model();
        forever begin
            @(posedge clk);
            if (rst_n) begin
                edge_cnt++;
                // the fetch address has to keep moving until ebreak stops it
                check_word("o_imem_raddr", imem_raddr, expected_fetch_addr(edge_cnt));
                if (retire.valid) begin
                    if (retired >= PROG_LEN) begin
                        timing_errors++;
                        $display("an instruction retired after ebreak at edge %0d", edge_cnt);
                    end else begin
                        if (edge_cnt != FIRST_RETIRE_EDGE + retired) begin
                            timing_errors++;
                            $display("instruction %0d retired at edge %0d instead of edge %0d",
                                     retired, edge_cnt, FIRST_RETIRE_EDGE + retired);
                        end
                        expected = step_model(prog[PROG_AW'(retired)]);
                        check_retire(retired, retire, expected);
                        retired++;
                    end
                end else if ((retired > 0) && (retired < PROG_LEN)) begin
                    timing_errors++;
                    $display("no instruction retired at edge %0d after instruction %0d",
                             edge_cnt, retired - 1);
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("the run did not finish within %0d ns", TIMEOUT_NS);
        report_counts();
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        wait (retired == PROG_LEN);
        // extra cycles so that a retire after ebreak would still be seen
        repeat (DRAIN_CYCLES) @(negedge clk);
        report_counts();
        if ((value_errors == 0) && (timing_errors == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
